//--- Makefile
# peripheral subsystem, verilator flow
TOP := periph_tb
BIN := obj_dir/V$(TOP)

.PHONY: lint sim clean

lint:
	verilator --lint-only -Wall --timing -f compile.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -Wno-fatal -f compile.f --top-module $(TOP)
	@out="$$(./$(BIN) +verilator+error+limit+100)"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "ALL TESTS PASSED"

clean:
	rm -rf obj_dir

//--- compile.f
+incdir+logic
logic/periph_pkg.sv
logic/wb_decoder.sv
logic/irq_ctrl.sv
logic/timer_unit.sv
logic/periph_top.sv
sim/periph_scoreboard.sv
sim/periph_chk.sv
sim/periph_tb.sv

//--- logic/irq_ctrl.sv
// platform interrupt controller, level sources only
// gateways, priority arbitration, claim/complete, target outputs
`include "periph_consts.svh"

module irq_ctrl (
    input  logic                 clk_i,
    input  logic                 rst_i,
    input  logic                 wr_i,
    input  logic                 rd_i,
    input  periph_pkg::addr_t    off_i,
    input  periph_pkg::data_t    wdata_i,
    input  periph_pkg::sel_t     wmask_i,
    output periph_pkg::data_t    rdata_o,
    input  periph_pkg::src_vec_t src_i,
    output periph_pkg::tgt_vec_t irq_o
);
    import periph_pkg::*;

    prio_t    prio_q   [`PERIPH_NUM_SRC];
    src_vec_t enable_q [`PERIPH_NUM_TGT];
    prio_t    thresh_q [`PERIPH_NUM_TGT];
    src_id_t  winner   [`PERIPH_NUM_TGT];
    src_vec_t pending_q;
    src_vec_t claimed_q;
    src_vec_t claimed_d;
    tgt_vec_t irq_q;
    src_vec_t prio_hit;
    tgt_vec_t enable_hit;
    tgt_vec_t thresh_hit;
    tgt_vec_t claim_hit;
    logic     pending_hit;
    logic     byte0_wr;

    // all fields live in the low byte
    assign byte0_wr = wr_i && wmask_i[0];

    always_comb begin
        pending_hit = (off_i == `PERIPH_IRQ_PENDING);
        for (int s = 0; s < `PERIPH_NUM_SRC; s++) begin
            prio_hit[s] = (off_i == addr_t'(`PERIPH_IRQ_PRIO_BASE + 4 * s));
        end
        for (int t = 0; t < `PERIPH_NUM_TGT; t++) begin
            enable_hit[t] = (off_i == addr_t'(`PERIPH_IRQ_ENABLE_BASE + 4 * t));
            thresh_hit[t] = (off_i == addr_t'(`PERIPH_IRQ_THRESH_BASE + 8 * t));
            claim_hit[t]  = (off_i == addr_t'(`PERIPH_IRQ_CLAIM_BASE + 8 * t));
        end
    end

    // highest priority above threshold, lowest id wins a tie
    always_comb begin
        prio_t best;
        for (int t = 0; t < `PERIPH_NUM_TGT; t++) begin
            winner[t] = '0;
            best      = thresh_q[t];
            for (int s = 1; s < `PERIPH_NUM_SRC; s++) begin
                if (pending_q[s] && enable_q[t][s] && (prio_q[s] > best)) begin
                    winner[t] = src_id_t'(s);
                    best      = prio_q[s];
                end
            end
        end
    end

    // claim marks the winner, complete releases the written id
    always_comb begin
        claimed_d = claimed_q;
        for (int t = 0; t < `PERIPH_NUM_TGT; t++) begin
            if (rd_i && claim_hit[t] && (winner[t] != '0)) begin
                claimed_d[winner[t]] = 1'b1;
            end
            if (byte0_wr && claim_hit[t]) begin
                claimed_d[wdata_i[$bits(src_id_t)-1:0]] = 1'b0;
            end
        end
        claimed_d[0] = 1'b0;
    end

    always_comb begin
        rdata_o = '0;
        if (pending_hit) begin
            rdata_o[`PERIPH_NUM_SRC-1:0] = pending_q;
        end
        for (int s = 0; s < `PERIPH_NUM_SRC; s++) begin
            if (prio_hit[s]) begin
                rdata_o[`PERIPH_PRIO_W-1:0] = prio_q[s];
            end
        end
        for (int t = 0; t < `PERIPH_NUM_TGT; t++) begin
            if (enable_hit[t]) begin
                rdata_o[`PERIPH_NUM_SRC-1:0] = enable_q[t];
            end
            if (thresh_hit[t]) begin
                rdata_o[`PERIPH_PRIO_W-1:0] = thresh_q[t];
            end
            if (claim_hit[t]) begin
                rdata_o[$bits(src_id_t)-1:0] = winner[t];
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            for (int s = 0; s < `PERIPH_NUM_SRC; s++) begin
                prio_q[s] <= '0;
            end
            for (int t = 0; t < `PERIPH_NUM_TGT; t++) begin
                enable_q[t] <= '0;
                thresh_q[t] <= '0;
            end
            pending_q <= '0;
            claimed_q <= '0;
            irq_q     <= '0;
        end else begin
            // source 0 stays at priority zero
            for (int s = 1; s < `PERIPH_NUM_SRC; s++) begin
                if (byte0_wr && prio_hit[s]) begin
                    prio_q[s] <= wdata_i[`PERIPH_PRIO_W-1:0];
                end
            end
            for (int t = 0; t < `PERIPH_NUM_TGT; t++) begin
                if (byte0_wr && enable_hit[t]) begin
                    enable_q[t] <= wdata_i[`PERIPH_NUM_SRC-1:0] & ~src_vec_t'(1);
                end
                if (byte0_wr && thresh_hit[t]) begin
                    thresh_q[t] <= wdata_i[`PERIPH_PRIO_W-1:0];
                end
                irq_q[t] <= (winner[t] != '0);
            end
            claimed_q <= claimed_d;
            // level gateway, held off while claimed
            pending_q <= src_i & ~claimed_d & ~src_vec_t'(1);
        end
    end

    assign irq_o = irq_q;

endmodule

//--- logic/periph_consts.svh
// widths, counts, address map and register offsets
// for the peripheral subsystem
`ifndef PERIPH_CONSTS_SVH
`define PERIPH_CONSTS_SVH

`define PERIPH_ADDR_W       12
`define PERIPH_DATA_W       32
`define PERIPH_NUM_SRC      8
`define PERIPH_NUM_TGT      2
`define PERIPH_PRIO_W       3
`define PERIPH_NUM_TIMER    2
`define PERIPH_REGION_W     2

// regions, taken from address bits 11:10
`define PERIPH_REG_IRQ      2'd0
`define PERIPH_REG_TIMER    2'd1
`define PERIPH_REG_SPI      2'd2
`define PERIPH_REG_ETH      2'd3

// interrupt source numbers
`define PERIPH_SRC_EXT0     1
`define PERIPH_SRC_EXT1     2
`define PERIPH_SRC_TIMER0   3

// interrupt controller offsets
`define PERIPH_IRQ_PRIO_BASE    12'h000
`define PERIPH_IRQ_PENDING      12'h080
`define PERIPH_IRQ_ENABLE_BASE  12'h100
`define PERIPH_IRQ_THRESH_BASE  12'h200
`define PERIPH_IRQ_CLAIM_BASE   12'h204

// timer offsets, one block of 0x10 per channel
`define PERIPH_TMR_STRIDE   12'h010
`define PERIPH_TMR_COUNT    12'h000
`define PERIPH_TMR_COMPARE  12'h004
`define PERIPH_TMR_CTRL     12'h008
`define PERIPH_TMR_EN_BIT     0
`define PERIPH_TMR_CLR_BIT    1
`define PERIPH_TMR_MATCH_BIT  2

`endif

//--- logic/periph_pkg.sv
// vector types and the bus state enum
`include "periph_consts.svh"

package periph_pkg;

    // bus fields
    typedef logic [`PERIPH_ADDR_W-1:0]   addr_t;
    typedef logic [`PERIPH_DATA_W-1:0]   data_t;
    typedef logic [`PERIPH_DATA_W/8-1:0] sel_t;

    // interrupt fields
    typedef logic [`PERIPH_NUM_SRC-1:0]         src_vec_t;
    typedef logic [$clog2(`PERIPH_NUM_SRC)-1:0] src_id_t;
    typedef logic [`PERIPH_PRIO_W-1:0]          prio_t;
    typedef logic [`PERIPH_NUM_TGT-1:0]         tgt_vec_t;

    // address region code
    typedef logic [`PERIPH_REGION_W-1:0] region_t;

    // decoder states
    typedef enum logic {
        IDLE,
        RESP
    } bus_state_t;

endpackage

//--- logic/periph_top.sv
// peripheral subsystem top level
// wishbone decode, interrupt controller and compare timer
`include "periph_consts.svh"

module periph_top (
    input  logic                          clk_i,
    input  logic                          rst_i,
    input  logic                          cyc_i,
    input  logic                          stb_i,
    input  logic                          we_i,
    input  periph_pkg::addr_t             adr_i,
    input  periph_pkg::data_t             dat_i,
    input  periph_pkg::sel_t              sel_i,
    output periph_pkg::data_t             dat_o,
    output logic                          ack_o,
    output logic                          err_o,
    input  logic [1:0]                    ext_irq_i,
    output periph_pkg::tgt_vec_t          irq_o
);
    import periph_pkg::*;

    logic                         irq_wr;
    logic                         irq_rd;
    logic                         tmr_wr;
    addr_t                        reg_off;
    data_t                        reg_wdata;
    sel_t                         reg_wmask;
    data_t                        irq_rdata;
    data_t                        tmr_rdata;
    logic [`PERIPH_NUM_TIMER-1:0] timer_irq;
    src_vec_t                     irq_src;

    // source 0 is reserved, the old uart/spi slots take the external lines
    assign irq_src[0] = 1'b0;
    assign irq_src[`PERIPH_SRC_EXT1:`PERIPH_SRC_EXT0] = ext_irq_i;
    assign irq_src[`PERIPH_SRC_TIMER0+`PERIPH_NUM_TIMER-1:`PERIPH_SRC_TIMER0] = timer_irq;
    assign irq_src[`PERIPH_NUM_SRC-1:`PERIPH_SRC_TIMER0+`PERIPH_NUM_TIMER] = '0;

    // ----------------------------------------
    // 1. decode
    // ----------------------------------------
    wb_decoder i_wb_decoder (
        .clk_i       ( clk_i     ),
        .rst_i       ( rst_i     ),
        .cyc_i       ( cyc_i     ),
        .stb_i       ( stb_i     ),
        .we_i        ( we_i      ),
        .adr_i       ( adr_i     ),
        .dat_i       ( dat_i     ),
        .sel_i       ( sel_i     ),
        .dat_o       ( dat_o     ),
        .ack_o       ( ack_o     ),
        .err_o       ( err_o     ),
        .irq_wr_o    ( irq_wr    ),
        .irq_rd_o    ( irq_rd    ),
        .tmr_wr_o    ( tmr_wr    ),
        // timer reads have no side effects
        .tmr_rd_o    (           ),
        .off_o       ( reg_off   ),
        .wdata_o     ( reg_wdata ),
        .wmask_o     ( reg_wmask ),
        .irq_rdata_i ( irq_rdata ),
        .tmr_rdata_i ( tmr_rdata )
    );

    // ----------------------------------------
    // 2. interrupt controller
    // ----------------------------------------
    irq_ctrl i_irq_ctrl (
        .clk_i   ( clk_i     ),
        .rst_i   ( rst_i     ),
        .wr_i    ( irq_wr    ),
        .rd_i    ( irq_rd    ),
        .off_i   ( reg_off   ),
        .wdata_i ( reg_wdata ),
        .wmask_i ( reg_wmask ),
        .rdata_o ( irq_rdata ),
        .src_i   ( irq_src   ),
        .irq_o   ( irq_o     )
    );

    // ----------------------------------------
    // 3. timer
    // ----------------------------------------
    timer_unit i_timer_unit (
        .clk_i       ( clk_i     ),
        .rst_i       ( rst_i     ),
        .wr_i        ( tmr_wr    ),
        .off_i       ( reg_off   ),
        .wdata_i     ( reg_wdata ),
        .wmask_i     ( reg_wmask ),
        .rdata_o     ( tmr_rdata ),
        .timer_irq_o ( timer_irq )
    );

endmodule

//--- logic/timer_unit.sv
// two-channel compare timer
// free running counters with sticky match interrupts
`include "periph_consts.svh"

module timer_unit (
    input  logic                         clk_i,
    input  logic                         rst_i,
    input  logic                         wr_i,
    input  periph_pkg::addr_t            off_i,
    input  periph_pkg::data_t            wdata_i,
    input  periph_pkg::sel_t             wmask_i,
    output periph_pkg::data_t            rdata_o,
    output logic [`PERIPH_NUM_TIMER-1:0] timer_irq_o
);
    import periph_pkg::*;

    data_t                        cnt_q [`PERIPH_NUM_TIMER];
    data_t                        cmp_q [`PERIPH_NUM_TIMER];
    logic [`PERIPH_NUM_TIMER-1:0] en_q;
    logic [`PERIPH_NUM_TIMER-1:0] match_q;
    logic [`PERIPH_NUM_TIMER-1:0] cnt_hit;
    logic [`PERIPH_NUM_TIMER-1:0] cmp_hit;
    logic [`PERIPH_NUM_TIMER-1:0] ctrl_hit;

    // byte-lane write merge
    function automatic data_t merge_bytes(data_t old_val, data_t new_val, sel_t mask);
        data_t res;
        res = old_val;
        for (int b = 0; b < $bits(sel_t); b++) begin
            if (mask[b]) begin
                res[8*b +: 8] = new_val[8*b +: 8];
            end
        end
        return res;
    endfunction

    always_comb begin
        for (int c = 0; c < `PERIPH_NUM_TIMER; c++) begin
            cnt_hit[c]  = (off_i == addr_t'(`PERIPH_TMR_STRIDE * c + `PERIPH_TMR_COUNT));
            cmp_hit[c]  = (off_i == addr_t'(`PERIPH_TMR_STRIDE * c + `PERIPH_TMR_COMPARE));
            ctrl_hit[c] = (off_i == addr_t'(`PERIPH_TMR_STRIDE * c + `PERIPH_TMR_CTRL));
        end
    end

    always_comb begin
        rdata_o = '0;
        for (int c = 0; c < `PERIPH_NUM_TIMER; c++) begin
            if (cnt_hit[c]) begin
                rdata_o = cnt_q[c];
            end
            if (cmp_hit[c]) begin
                rdata_o = cmp_q[c];
            end
            if (ctrl_hit[c]) begin
                rdata_o[`PERIPH_TMR_EN_BIT]    = en_q[c];
                rdata_o[`PERIPH_TMR_MATCH_BIT] = match_q[c];
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            for (int c = 0; c < `PERIPH_NUM_TIMER; c++) begin
                cnt_q[c] <= '0;
                cmp_q[c] <= '0;
            end
            en_q    <= '0;
            match_q <= '0;
        end else begin
            for (int c = 0; c < `PERIPH_NUM_TIMER; c++) begin
                // wrap to zero on compare
                if (en_q[c]) begin
                    if (cnt_q[c] == cmp_q[c]) begin
                        cnt_q[c]   <= '0;
                        match_q[c] <= 1'b1;
                    end else begin
                        cnt_q[c] <= cnt_q[c] + 1'b1;
                    end
                end
                // bus writes override the count
                if (wr_i && cnt_hit[c]) begin
                    cnt_q[c] <= merge_bytes(cnt_q[c], wdata_i, wmask_i);
                end
                if (wr_i && cmp_hit[c]) begin
                    cmp_q[c] <= merge_bytes(cmp_q[c], wdata_i, wmask_i);
                end
                if (wr_i && ctrl_hit[c] && wmask_i[0]) begin
                    en_q[c] <= wdata_i[`PERIPH_TMR_EN_BIT];
                    if (wdata_i[`PERIPH_TMR_CLR_BIT]) begin
                        match_q[c] <= 1'b0;
                    end
                end
            end
        end
    end

    assign timer_irq_o = match_q;

endmodule

//--- logic/wb_decoder.sv
// wishbone classic slave front end
// region decode, registered ack/err and read data capture
`include "periph_consts.svh"

module wb_decoder (
    input  logic              clk_i,
    input  logic              rst_i,
    input  logic              cyc_i,
    input  logic              stb_i,
    input  logic              we_i,
    input  periph_pkg::addr_t adr_i,
    input  periph_pkg::data_t dat_i,
    input  periph_pkg::sel_t  sel_i,
    output periph_pkg::data_t dat_o,
    output logic              ack_o,
    output logic              err_o,
    output logic              irq_wr_o,
    output logic              irq_rd_o,
    output logic              tmr_wr_o,
    output logic              tmr_rd_o,
    output periph_pkg::addr_t off_o,
    output periph_pkg::data_t wdata_o,
    output periph_pkg::sel_t  wmask_o,
    input  periph_pkg::data_t irq_rdata_i,
    input  periph_pkg::data_t tmr_rdata_i
);
    import periph_pkg::*;

    bus_state_t state_q;
    region_t    region;
    logic       req;
    logic       irq_sel;
    logic       tmr_sel;
    logic       err_sel;
    data_t      rdata_mux;

    // stb is ignored in RESP, one access in flight
    assign req     = (state_q == IDLE) && cyc_i && stb_i;
    assign region  = adr_i[`PERIPH_ADDR_W-1 -: `PERIPH_REGION_W];
    assign irq_sel = (region == `PERIPH_REG_IRQ);
    assign tmr_sel = (region == `PERIPH_REG_TIMER);
    // former spi and ethernet windows
    assign err_sel = (region == `PERIPH_REG_SPI) || (region == `PERIPH_REG_ETH);

    assign irq_wr_o = req && irq_sel && we_i;
    assign irq_rd_o = req && irq_sel && !we_i;
    assign tmr_wr_o = req && tmr_sel && we_i;
    assign tmr_rd_o = req && tmr_sel && !we_i;

    assign off_o   = {{`PERIPH_REGION_W{1'b0}}, adr_i[`PERIPH_ADDR_W-`PERIPH_REGION_W-1:0]};
    assign wdata_o = dat_i;
    assign wmask_o = sel_i;

    // writes and errored reads return zero
    always_comb begin
        rdata_mux = '0;
        if (irq_rd_o) begin
            rdata_mux = irq_rdata_i;
        end else if (tmr_rd_o) begin
            rdata_mux = tmr_rdata_i;
        end
    end

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            state_q <= IDLE;
            ack_o   <= 1'b0;
            err_o   <= 1'b0;
            dat_o   <= '0;
        end else begin
            case (state_q)
                IDLE: begin
                    if (req) begin
                        state_q <= RESP;
                        ack_o   <= !err_sel;
                        err_o   <= err_sel;
                        dat_o   <= rdata_mux;
                    end
                end
                RESP: begin
                    state_q <= IDLE;
                    ack_o   <= 1'b0;
                    err_o   <= 1'b0;
                end
                default: state_q <= IDLE;
            endcase
        end
    end

endmodule

//--- sim/periph_chk.sv
// bus and interrupt assertions, bound into periph_top
module periph_chk (
    input logic                 clk_i,
    input logic                 rst_i,
    input logic                 cyc_i,
    input logic                 stb_i,
    input logic                 ack_i,
    input logic                 err_i,
    input periph_pkg::tgt_vec_t irq_i
);
    int assert_fails = 0;

    ack_err_excl: assert property (@(posedge clk_i) disable iff (rst_i) !(ack_i && err_i))
        else begin
            $error("ack_o and err_o high in the same cycle");
            assert_fails++;
        end

    // single cycle response
    resp_pulse: assert property (@(posedge clk_i) disable iff (rst_i)
        (ack_i || err_i) |=> !(ack_i || err_i))
        else begin
            $error("ack_o or err_o held longer than one cycle");
            assert_fails++;
        end

    resp_after_req: assert property (@(posedge clk_i) disable iff (rst_i)
        (ack_i || err_i) |-> $past(cyc_i && stb_i))
        else begin
            $error("response without a request in the previous cycle");
            assert_fails++;
        end

    irq_in_reset: assert property (@(posedge clk_i) rst_i |=> (!rst_i || (irq_i == '0)))
        else begin
            $error("irq_o not low while reset is held");
            assert_fails++;
        end

endmodule

bind periph_top periph_chk i_periph_chk (
    .clk_i ( clk_i ),
    .rst_i ( rst_i ),
    .cyc_i ( cyc_i ),
    .stb_i ( stb_i ),
    .ack_i ( ack_o ),
    .err_i ( err_o ),
    .irq_i ( irq_o )
);

//--- sim/periph_scoreboard.sv
// result checking for the peripheral testbench
// bus responses and interrupt levels against trace expectations
module periph_scoreboard (
    input  logic                 clk_i,
    input  logic                 rst_i,
    input  logic                 bus_pend_i,
    input  logic                 irq_pend_i,
    input  logic                 timeout_i,
    input  logic                 exp_err_i,
    input  logic                 chk_data_i,
    input  periph_pkg::addr_t    exp_adr_i,
    input  periph_pkg::data_t    exp_data_i,
    input  periph_pkg::tgt_vec_t exp_irq_i,
    input  logic                 ack_i,
    input  logic                 err_i,
    input  periph_pkg::data_t    dat_i,
    input  periph_pkg::tgt_vec_t irq_i,
    output int                   pass_cnt_o,
    output int                   fail_cnt_o
);
    import periph_pkg::*;

    logic bad;

    function automatic string bus_name();
        string kind;
        if (exp_err_i) begin
            kind = "error access";
        end else if (chk_data_i) begin
            kind = "read";
        end else begin
            kind = "write";
        end
        return $sformatf("%s at 0x%03h", kind, exp_adr_i);
    endfunction

    task automatic close_test(input logic failed, input string name);
        if (failed) begin
            fail_cnt_o = fail_cnt_o + 1;
            $display("test %0d: %s ... FAIL", pass_cnt_o + fail_cnt_o, name);
        end else begin
            pass_cnt_o = pass_cnt_o + 1;
            $display("test %0d: %s ... ok", pass_cnt_o + fail_cnt_o, name);
        end
    endtask

    // ----------------------------------------
    // compare on each response or irq match
    // ----------------------------------------
    always @(posedge clk_i) begin
        if (rst_i) begin
            pass_cnt_o = 0;
            fail_cnt_o = 0;
        end else if (timeout_i) begin
            fail_cnt_o = fail_cnt_o + 1;
            if (irq_pend_i) begin
                $display("test %0d: irq_o never reached %b within the wait limit, still %b",
                         pass_cnt_o + fail_cnt_o, exp_irq_i, irq_i);
            end else begin
                $display("test %0d: no ack or err within the wait limit for %s",
                         pass_cnt_o + fail_cnt_o, bus_name());
            end
        end else if (bus_pend_i && (ack_i || err_i)) begin
            bad = 1'b0;
            if (ack_i !== !exp_err_i) begin
                $display("MISMATCH at %0t: ack_o expected %b got %b", $time, !exp_err_i, ack_i);
                bad = 1'b1;
            end
            if (err_i !== exp_err_i) begin
                $display("MISMATCH at %0t: err_o expected %b got %b", $time, exp_err_i, err_i);
                bad = 1'b1;
            end
            if (chk_data_i && (dat_i !== exp_data_i)) begin
                $display("MISMATCH at %0t: dat_o expected 0x%08h got 0x%08h",
                         $time, exp_data_i, dat_i);
                bad = 1'b1;
            end
            close_test(bad, bus_name());
        end else if (irq_pend_i && (irq_i == exp_irq_i)) begin
            close_test(1'b0, $sformatf("irq_o reached %b", exp_irq_i));
        end
    end

endmodule

//--- sim/periph_tb.sv
// testbench top for the peripheral subsystem
// clock, reset, trace replay and wishbone host
module periph_tb;
    import periph_pkg::*;

    localparam int         TRACE_DEPTH = 64;
    localparam int         WAIT_LIMIT  = 200;
    localparam logic [3:0] OP_END      = 4'h0;
    localparam logic [3:0] OP_WRITE    = 4'h1;
    localparam logic [3:0] OP_READ     = 4'h2;
    localparam logic [3:0] OP_ERR      = 4'h3;
    localparam logic [3:0] OP_EXT      = 4'h4;
    localparam logic [3:0] OP_IRQ      = 4'h5;

    logic       clk;
    logic       rst;
    logic       cyc;
    logic       stb;
    logic       we;
    addr_t      adr;
    data_t      wdat;
    sel_t       sel;
    data_t      rdat;
    logic       ack;
    logic       err;
    logic [1:0] ext_irq;
    tgt_vec_t   irq;

    // expectations handed to the scoreboard
    logic     bus_pend;
    logic     irq_pend;
    logic     timeout;
    logic     exp_err;
    logic     chk_data;
    addr_t    exp_adr;
    data_t    exp_data;
    tgt_vec_t exp_irq;
    int       pass_cnt;
    int       fail_cnt;

    // op in 47:44, address in 43:32, data in 31:0
    logic [47:0] trace_mem [TRACE_DEPTH];

    periph_top i_periph_top (
        .clk_i     ( clk     ),
        .rst_i     ( rst     ),
        .cyc_i     ( cyc     ),
        .stb_i     ( stb     ),
        .we_i      ( we      ),
        .adr_i     ( adr     ),
        .dat_i     ( wdat    ),
        .sel_i     ( sel     ),
        .dat_o     ( rdat    ),
        .ack_o     ( ack     ),
        .err_o     ( err     ),
        .ext_irq_i ( ext_irq ),
        .irq_o     ( irq     )
    );

    periph_scoreboard i_periph_scoreboard (
        .clk_i      ( clk      ),
        .rst_i      ( rst      ),
        .bus_pend_i ( bus_pend ),
        .irq_pend_i ( irq_pend ),
        .timeout_i  ( timeout  ),
        .exp_err_i  ( exp_err  ),
        .chk_data_i ( chk_data ),
        .exp_adr_i  ( exp_adr  ),
        .exp_data_i ( exp_data ),
        .exp_irq_i  ( exp_irq  ),
        .ack_i      ( ack      ),
        .err_i      ( err      ),
        .dat_i      ( rdat     ),
        .irq_i      ( irq      ),
        .pass_cnt_o ( pass_cnt ),
        .fail_cnt_o ( fail_cnt )
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // ----------------------------------------
    // host side tasks
    // ----------------------------------------
    task automatic bus_cycle(input logic write, input addr_t a, input data_t d,
                             input logic want_err, input data_t want, input logic check);
        int waited;
        waited = 0;
        @(posedge clk);
        cyc      <= 1'b1;
        stb      <= 1'b1;
        we       <= write;
        adr      <= a;
        wdat     <= d;
        sel      <= '1;
        bus_pend <= 1'b1;
        exp_err  <= want_err;
        chk_data <= check;
        exp_adr  <= a;
        exp_data <= want;
        @(posedge clk);
        while (!(ack || err) && (waited < WAIT_LIMIT)) begin
            @(posedge clk);
            waited++;
        end
        // strobe drops in the cycle after the response
        cyc <= 1'b0;
        stb <= 1'b0;
        if (!(ack || err)) begin
            timeout <= 1'b1;
            @(posedge clk);
            timeout <= 1'b0;
        end
        bus_pend <= 1'b0;
    endtask

    task automatic wait_irq(input tgt_vec_t want);
        int waited;
        waited = 0;
        @(posedge clk);
        irq_pend <= 1'b1;
        exp_irq  <= want;
        @(posedge clk);
        while ((irq != want) && (waited < WAIT_LIMIT)) begin
            @(posedge clk);
            waited++;
        end
        if (irq != want) begin
            timeout <= 1'b1;
            @(posedge clk);
            timeout <= 1'b0;
        end
        irq_pend <= 1'b0;
    endtask

    task automatic drive_ext_lines(input logic [1:0] lines);
        @(posedge clk);
        ext_irq <= lines;
    endtask

    // ----------------------------------------
    // trace replay
    // ----------------------------------------
    initial begin
        logic [3:0] op;
        addr_t      a;
        data_t      d;
        int         idx;
        int         bad_ops;
        int         fails;

        rst      = 1'b1;
        cyc      = 1'b0;
        stb      = 1'b0;
        we       = 1'b0;
        adr      = '0;
        wdat     = '0;
        sel      = '0;
        ext_irq  = '0;
        bus_pend = 1'b0;
        irq_pend = 1'b0;
        timeout  = 1'b0;
        exp_err  = 1'b0;
        chk_data = 1'b0;
        exp_adr  = '0;
        exp_data = '0;
        exp_irq  = '0;
        bad_ops  = 0;
        for (int i = 0; i < TRACE_DEPTH; i++) begin
            trace_mem[i] = '0;
        end
        $readmemh("sim/periph_trace.txt", trace_mem);

        repeat (8) @(posedge clk);
        rst <= 1'b0;

        idx = 0;
        while ((idx < TRACE_DEPTH) && (trace_mem[idx][47:44] != OP_END)) begin
            {op, a, d} = trace_mem[idx];
            case (op)
                OP_WRITE: bus_cycle(1'b1, a, d, 1'b0, '0, 1'b0);
                OP_READ:  bus_cycle(1'b0, a, '0, 1'b0, d, 1'b1);
                // errored accesses read back zero
                OP_ERR:   bus_cycle(d != '0, a, d, 1'b1, '0, 1'b1);
                OP_EXT:   drive_ext_lines(d[1:0]);
                OP_IRQ:   wait_irq(d[$bits(tgt_vec_t)-1:0]);
                default: begin
                    $display("trace entry %0d holds an unknown operation %0h", idx, op);
                    bad_ops++;
                end
            endcase
            idx++;
        end

        repeat (4) @(posedge clk);
        fails = fail_cnt + bad_ops + i_periph_top.i_periph_chk.assert_fails;
        $display("tests run %0d, passed %0d, failed %0d, assertion failures %0d",
                 pass_cnt + fail_cnt, pass_cnt, fail_cnt,
                 i_periph_top.i_periph_chk.assert_fails);
        if ((fails == 0) && (pass_cnt > 0)) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

//--- sim/periph_trace.txt
// op_addr_data: op 1 write, 2 read and compare, 3 access expecting err (nonzero data
// writes it), 4 drive ext_irq_i, 5 wait for irq_o to equal data, 0 ends the trace
// priorities, enables, thresholds
1_004_00000003
1_008_00000005
1_010_00000002
1_100_00000006
1_104_00000010
1_200_00000001
2_004_00000003
2_008_00000005
2_100_00000006
2_104_00000010
2_200_00000001
// old spi and ethernet windows
3_800_00000000
3_c04_000000a5
// both lines high, source 2 wins on priority
4_000_00000003
5_000_00000001
2_080_00000006
2_204_00000002
2_080_00000002
1_204_00000002
2_080_00000006
// equal priority goes to the lower number
1_004_00000005
2_204_00000001
1_204_00000001
// threshold at the top priority masks both
1_200_00000005
5_000_00000000
2_204_00000000
4_000_00000000
// timer channel 1, source 4 on target 1
1_414_00000010
1_418_00000001
5_000_00000002
2_418_00000005
2_20c_00000004
1_418_00000002
1_20c_00000004
2_418_00000000
5_000_00000000
